// ==== design/conFieldPkg.sv ====
package conFieldPkg;

  localparam int condWidth = 6;
  localparam int magicWidth = 9;
  localparam int condGroupCount = 8;

  // COND codes, octal
  localparam logic [condWidth-1:0] condLoadIr = 6'o14;
  localparam logic [condWidth-1:0] condSpecInstr = 6'o15;
  localparam logic [condWidth-1:0] condSrMagic = 6'o16;
  localparam logic [condWidth-1:0] condSelVma = 6'o17;
  localparam logic [condWidth-1:0] condDiagFunc = 6'o20;
  localparam logic [condWidth-1:0] condEbusCtl = 6'o22;
  // 30 through this code are VMA magic
  localparam logic [condWidth-1:0] condVmaMagicLast = 6'o34;
  localparam logic [condWidth-1:0] condVmaDec = 6'o35;
  localparam logic [condWidth-1:0] condVmaInc = 6'o36;
  localparam logic [condWidth-1:0] condLoadVmaHeld = 6'o37;

  // I/O functions are MAGIC 01x
  localparam logic [2:0] funcTopDigit = 3'o0;
  localparam logic [2:0] funcMidDigit = 3'o1;

  localparam logic [2:0] funcConoApr = 3'o4;
  localparam logic [2:0] funcConoPi = 3'o5;
  localparam logic [2:0] funcConoPag = 3'o6;
  localparam logic [2:0] funcDataoApr = 3'o7;

endpackage

// ==== design/conDiagPkg.sv ====
package conDiagPkg;

  // Readback rows sit on EBUS bits 18 up
  localparam int ebusDiagBase = 18;
  localparam int diagRowCount = 7;

  localparam int diagSelWidth = 3;
  localparam int diagEntryCount = 1 << diagSelWidth;

  localparam logic [diagSelWidth-1:0] diagSelParity = 3'd0;
  localparam logic [diagSelWidth-1:0] diagSelPaging = 3'd1;
  localparam logic [diagSelWidth-1:0] diagSelRun = 3'd2;

  // Console diagnostic function codes
  localparam int dsWidth = 3;
  localparam logic [dsWidth-1:0] dsClearRun = 3'd0;
  localparam logic [dsWidth-1:0] dsSetRun = 3'd1;
  localparam logic [dsWidth-1:0] dsContinue = 3'd2;
  localparam logic [dsWidth-1:0] dsIrStrobe = 3'd4;

  localparam int runDelayStages = 3;

endpackage

// ==== design/condDecode.sv ====
module condDecode import conFieldPkg::*; (
  input  logic                      conCLK,
  input  logic                      CLK,
  input  logic [condWidth-1:0]      cond,
  input  logic                      mclLoadVma,
  input  logic                      diagIrStrobe,
  output logic [condGroupCount-1:0] condGroupEn,
  output logic                      condDiagFunc,
  output logic                      condEbusCtl,
  output logic                      condSrMagic,
  output logic                      condSpecInstr,
  output logic                      condSelVma,
  output logic                      condLoadVmaHeld,
  output logic                      condVmaMagic,
  output logic [1:0]                vmaSel,
  output logic                      loadIr
);

  logic       decodeEn;
  logic [2:0] condGroup;
  logic [2:0] condLow;
  logic       vmaDecHit;
  logic       vmaIncHit;
  logic       loadIrHit;

  assign decodeEn = ~CLK;
  assign condGroup = cond[condWidth-1:3];
  assign condLow = cond[2:0];

  // One enable per top octal digit, none while in reset
  always_comb begin
    condGroupEn = '0;
    if (decodeEn) begin
      condGroupEn[condGroup] = 1'b1;
    end
  end

  assign condDiagFunc = decodeEn && (cond == conFieldPkg::condDiagFunc);
  assign condEbusCtl = decodeEn && (cond == conFieldPkg::condEbusCtl);
  assign condSrMagic = decodeEn && (cond == conFieldPkg::condSrMagic);
  assign condSpecInstr = decodeEn && (cond == conFieldPkg::condSpecInstr);
  assign condSelVma = decodeEn && (cond == conFieldPkg::condSelVma);
  assign condLoadVmaHeld = decodeEn && (cond == conFieldPkg::condLoadVmaHeld);

  // 30..34 all mean VMA magic
  assign condVmaMagic = decodeEn && (condGroup == condVmaMagicLast[condWidth-1:3]) &&
                        (condLow <= condVmaMagicLast[2:0]);

  assign vmaDecHit = decodeEn && (cond == condVmaDec);
  assign vmaIncHit = decodeEn && (cond == condVmaInc);
  assign loadIrHit = decodeEn && (cond == condLoadIr);

  assign vmaSel[1] = vmaDecHit | mclLoadVma;
  assign vmaSel[0] = vmaIncHit | mclLoadVma;
  assign loadIr = loadIrHit | diagIrStrobe;

  groupEnOneHot: assert property (@(posedge conCLK) !CLK |-> $onehot(condGroupEn));

endmodule

// ==== design/ioFunctionDecode.sv ====
module ioFunctionDecode import conFieldPkg::*; (
  input  logic                  conCLK,
  input  logic                  CLK,
  input  logic [magicWidth-1:0] magic,
  input  logic                  condDiagFunc,
  input  logic                  condEbusCtl,
  input  logic                  consoleControl,
  input  logic                  ebusSync,
  input  logic [35:0]           ebusIn,
  output logic                  conoApr,
  output logic                  conoPi,
  output logic                  conoPag,
  output logic                  dataoApr,
  output logic                  ebusRel,
  output logic                  wrEvenParAdr,
  output logic                  wrEvenParData,
  output logic                  wrEvenParDir,
  output logic                  cacheLookEn,
  output logic                  cacheLoadEn,
  output logic                  ki10PagingMode,
  output logic                  trapEn
);

  logic [2:0] magicTop;
  logic [2:0] magicMid;
  logic [2:0] magicLow;
  logic       ioFuncEn;
  logic       kl10PagingEn;

  assign magicTop = magic[magicWidth-1:6];
  assign magicMid = magic[5:3];
  assign magicLow = magic[2:0];

  // MAGIC 01x under a diag function, locked out from the console
  assign ioFuncEn = !CLK && condDiagFunc && !consoleControl &&
                    (magicTop == funcTopDigit) && (magicMid == funcMidDigit);

  assign conoApr = ioFuncEn && ebusSync && (magicLow == funcConoApr);
  assign conoPi = ioFuncEn && ebusSync && (magicLow == funcConoPi);
  assign conoPag = ioFuncEn && (magicLow == funcConoPag);
  assign dataoApr = ioFuncEn && (magicLow == funcDataoApr);

  assign ebusRel = ~(condEbusCtl & magic[2] & ebusSync);

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      wrEvenParAdr <= 1'b0;
      wrEvenParData <= 1'b0;
      wrEvenParDir <= 1'b0;
      cacheLookEn <= 1'b0;
      cacheLoadEn <= 1'b0;
      kl10PagingEn <= 1'b0;
      trapEn <= 1'b0;
    end else begin
      if (conoPi) begin
        wrEvenParAdr <= ebusIn[18];
        wrEvenParData <= ebusIn[19];
        wrEvenParDir <= ebusIn[20];
      end
      if (conoPag) begin
        cacheLookEn <= ebusIn[18];
        cacheLoadEn <= ebusIn[19];
        kl10PagingEn <= ebusIn[21];
        trapEn <= ebusIn[22];
      end
    end
  end

  assign ki10PagingMode = ~kl10PagingEn;

  strobeOneHot: assert property (@(posedge conCLK)
    $onehot0({conoApr, conoPi, conoPag, dataoApr}));

endmodule

// ==== design/runControl.sv ====
module runControl import conDiagPkg::*; (
  input  logic               conCLK,
  input  logic               CLK,
  input  logic               diagCtlStrobe,
  input  logic [dsWidth-1:0] diagDs,
  output logic               run,
  output logic               start,
  output logic               diagIrStrobe
);

  logic                      runState;
  logic                      startReq;
  logic [runDelayStages-1:0] runChain;
  logic [runDelayStages-1:0] startChain;

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runState <= 1'b0;
      startReq <= 1'b0;
      runChain <= '0;
      startChain <= '0;
    end else begin
      if (diagCtlStrobe && diagDs == dsSetRun) begin
        runState <= 1'b1;
      end else if (diagCtlStrobe && diagDs == dsClearRun) begin
        runState <= 1'b0;
      end
      // Request drops once the start pulse is out
      if (diagCtlStrobe && diagDs == dsContinue) begin
        startReq <= 1'b1;
      end else if (start) begin
        startReq <= 1'b0;
      end
      runChain <= {runChain[runDelayStages-2:0], runState};
      // Only launch into an empty chain so start is a single pulse
      startChain <= {startChain[runDelayStages-2:0], startReq & ~(|startChain)};
    end
  end

  assign run = runChain[runDelayStages-1];
  assign start = startChain[runDelayStages-1];
  assign diagIrStrobe = diagCtlStrobe && (diagDs == dsIrStrobe);

  startSinglePulse: assert property (@(posedge conCLK) disable iff (CLK) start |=> !start);

endmodule

// ==== design/diagStatusGather.sv ====
module diagStatusGather import conDiagPkg::*; (
  input  logic                                         wrEvenParAdr,
  input  logic                                         wrEvenParData,
  input  logic                                         wrEvenParDir,
  input  logic                                         cacheLookEn,
  input  logic                                         cacheLoadEn,
  input  logic                                         ki10PagingMode,
  input  logic                                         trapEn,
  input  logic                                         run,
  input  logic                                         loadIr,
  output logic [diagRowCount-1:0][diagEntryCount-1:0] rowEntries
);

  always_comb begin
    rowEntries = '0;

    // Parity write enables
    rowEntries[0][diagSelParity] = wrEvenParAdr;
    rowEntries[1][diagSelParity] = wrEvenParData;
    rowEntries[2][diagSelParity] = wrEvenParDir;

    // Cache and paging
    rowEntries[0][diagSelPaging] = cacheLookEn;
    rowEntries[1][diagSelPaging] = cacheLoadEn;
    rowEntries[3][diagSelPaging] = ki10PagingMode;
    rowEntries[4][diagSelPaging] = trapEn;

    // Run state, load IR reads back inverted
    rowEntries[0][diagSelRun] = run;
    rowEntries[4][diagSelRun] = ~loadIr;
  end

endmodule

// ==== design/diagRowMux.sv ====
module diagRowMux import conDiagPkg::*; (
  input  logic                      conCLK,
  input  logic                      CLK,
  input  logic [diagEntryCount-1:0] entries,
  input  logic [diagSelWidth-1:0]   diagSel,
  input  logic                      capture,
  output logic                      rowBit
);

  // Held until the next capture
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      rowBit <= 1'b0;
    end else if (capture) begin
      rowBit <= entries[diagSel];
    end
  end

endmodule

// ==== design/diagReadPort.sv ====
module diagReadPort import conDiagPkg::*; (
  input  logic                                               conCLK,
  input  logic                                               CLK,
  input  logic                                               diagReq,
  input  logic [diagRowCount-1:0]                            rowBits,
  output logic                                               capture,
  output logic                                               diagAck,
  output logic [ebusDiagBase+diagRowCount-1:ebusDiagBase]   ebusDiag
);

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      capture <= 1'b0;
      diagAck <= 1'b0;
    end else begin
      // New request only once the previous one is fully retired
      capture <= diagReq && !diagAck && !capture;
      if (capture) begin
        diagAck <= 1'b1;
      end else if (!diagReq) begin
        diagAck <= 1'b0;
      end
    end
  end

  // Rows are captured on the same edge that raises diagAck
  assign ebusDiag = diagAck ? rowBits : '0;

  ackNeedsReq: assert property (@(posedge conCLK) disable iff (CLK)
    $rose(diagAck) |-> $past(diagReq));

endmodule

// ==== design/conCore.sv ====
module conCore import conFieldPkg::*, conDiagPkg::*; (
  input  logic                                             conCLK,
  input  logic                                             CLK,
  input  logic [condWidth-1:0]                             cond,
  input  logic                                             mclLoadVma,
  input  logic [magicWidth-1:0]                            magic,
  input  logic                                             consoleControl,
  input  logic                                             ebusSync,
  input  logic [35:0]                                      ebusIn,
  input  logic                                             diagCtlStrobe,
  input  logic [dsWidth-1:0]                               diagDs,
  input  logic                                             diagReq,
  input  logic [diagSelWidth-1:0]                          diagSel,
  output logic [condGroupCount-1:0]                        condGroupEn,
  output logic                                             condDiagFunc,
  output logic                                             condEbusCtl,
  output logic                                             condSrMagic,
  output logic                                             condSpecInstr,
  output logic                                             condSelVma,
  output logic                                             condLoadVmaHeld,
  output logic                                             condVmaMagic,
  output logic [1:0]                                       vmaSel,
  output logic                                             loadIr,
  output logic                                             conoApr,
  output logic                                             conoPi,
  output logic                                             conoPag,
  output logic                                             dataoApr,
  output logic                                             ebusRel,
  output logic                                             wrEvenParAdr,
  output logic                                             wrEvenParData,
  output logic                                             wrEvenParDir,
  output logic                                             cacheLookEn,
  output logic                                             cacheLoadEn,
  output logic                                             ki10PagingMode,
  output logic                                             trapEn,
  output logic                                             run,
  output logic                                             start,
  output logic                                             diagAck,
  output logic [ebusDiagBase+diagRowCount-1:ebusDiagBase] ebusDiag
);

  logic                                        diagIrStrobe;
  logic                                        capture;
  logic [diagRowCount-1:0][diagEntryCount-1:0] rowEntries;
  logic [diagRowCount-1:0]                     rowBits;

  condDecode condDecode0 (.*);

  ioFunctionDecode ioFunctionDecode0 (.*);

  runControl runControl0 (.*);

  diagStatusGather diagStatusGather0 (.*);

  // One capture mux per EBUS readback bit
  for (genvar r = 0; r < diagRowCount; r++) begin : diagRows
    diagRowMux rowMux (
      .conCLK  (conCLK),
      .CLK     (CLK),
      .entries (rowEntries[r]),
      .diagSel (diagSel),
      .capture (capture),
      .rowBit  (rowBits[r])
    );
  end

  diagReadPort diagReadPort0 (.*);

endmodule

// ==== tests/conClockGen.sv ====
module conClockGen (
  output logic conCLK,
  output logic CLK
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int periodNs = 20;
  localparam int resetCycles = 5;

  initial begin
    conCLK = 1'b0;
    forever #(periodNs / 2) conCLK = ~conCLK;
  end

  // Reset drops on a falling edge, away from the sampling edge
  initial begin
    CLK = 1'b1;
    repeat (resetCycles) @(posedge conCLK);
    @(negedge conCLK);
    CLK = 1'b0;
  end

endmodule

// ==== tests/conCoreTb.sv ====
module conCoreTb import conFieldPkg::*, conDiagPkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clockPeriodNs = 20;
  localparam int ioCount = 200;
  localparam int testCycles = 6 + 64 + ioCount + 24 + 22 + 46 + 8;
  localparam int watchdogNs = 2 * testCycles * clockPeriodNs;

  logic conCLK, CLK;
  logic [condWidth-1:0] cond;
  logic [magicWidth-1:0] magic;
  logic [35:0] ebusIn;
  logic [dsWidth-1:0] diagDs;
  logic [diagSelWidth-1:0] diagSel;
  logic mclLoadVma, consoleControl, ebusSync, diagCtlStrobe, diagReq;
  logic [condGroupCount-1:0] condGroupEn;
  logic condDiagFunc, condEbusCtl, condSrMagic, condSpecInstr, condSelVma, condLoadVmaHeld;
  logic condVmaMagic, loadIr, conoApr, conoPi, conoPag, dataoApr, ebusRel;
  logic wrEvenParAdr, wrEvenParData, wrEvenParDir, cacheLookEn, cacheLoadEn;
  logic ki10PagingMode, trapEn, run, start, diagAck;
  logic [1:0] vmaSel;
  logic [ebusDiagBase+diagRowCount-1:ebusDiagBase] ebusDiag;

  // Reference model
  logic mParAdr, mParData, mParDir, mLook, mLoad, mKl10, mTrap, mRunState, mCap, mAck;
  logic [2:0] runPipe;
  logic [3:0] contPipe;
  logic [diagRowCount-1:0] mRows;
  logic [9:0] expCondOut, gotCondOut;
  logic [4:0] expIo, gotIo;
  logic [6:0] expRegs, gotRegs;
  logic ioOk, expLoadIr;
  integer seed;
  int errorCount, testCount, errorsAtStart;

  conClockGen clockGen0 (.conCLK(conCLK), .CLK(CLK));
  conCore dut0 (.*);

  assign expLoadIr = cond == conFieldPkg::condLoadIr || (diagCtlStrobe && diagDs == dsIrStrobe);
  assign expCondOut = {cond == conFieldPkg::condDiagFunc, cond == conFieldPkg::condEbusCtl,
    cond == conFieldPkg::condSrMagic, cond == conFieldPkg::condSpecInstr,
    cond == conFieldPkg::condSelVma, cond == conFieldPkg::condLoadVmaHeld,
    cond >= 6'o30 && cond <= condVmaMagicLast, cond == condVmaDec || mclLoadVma,
    cond == condVmaInc || mclLoadVma, expLoadIr};
  assign gotCondOut = {condDiagFunc, condEbusCtl, condSrMagic, condSpecInstr, condSelVma,
    condLoadVmaHeld, condVmaMagic, vmaSel, loadIr};
  assign ioOk = cond == conFieldPkg::condDiagFunc && magic[8:6] == funcTopDigit &&
    magic[5:3] == funcMidDigit && !consoleControl;
  assign expIo = {ioOk && ebusSync && magic[2:0] == funcConoApr,
    ioOk && ebusSync && magic[2:0] == funcConoPi, ioOk && magic[2:0] == funcConoPag,
    ioOk && magic[2:0] == funcDataoApr, !(cond == conFieldPkg::condEbusCtl && magic[2] && ebusSync)};
  assign gotIo = {conoApr, conoPi, conoPag, dataoApr, ebusRel};
  assign expRegs = {mParAdr, mParData, mParDir, mLook, mLoad, ~mKl10, mTrap};
  assign gotRegs = {wrEvenParAdr, wrEvenParData, wrEvenParDir, cacheLookEn, cacheLoadEn,
    ki10PagingMode, trapEn};

  function automatic logic [diagRowCount-1:0] expRows(input logic [diagSelWidth-1:0] sel);
    case (sel)
      diagSelParity: return {4'b0, mParDir, mParData, mParAdr};
      diagSelPaging: return {2'b0, mTrap, ~mKl10, 1'b0, mLoad, mLook};
      diagSelRun: return {2'b0, ~expLoadIr, 3'b0, runPipe[2]};
      default: return '0;
    endcase
  endfunction

  always @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      {mParAdr, mParData, mParDir, mLook, mLoad, mKl10, mTrap} <= '0;
      {mRunState, mCap, mAck, runPipe, contPipe, mRows} <= '0;
    end else begin
      if (expIo[3]) {mParDir, mParData, mParAdr} <= ebusIn[20:18];
      if (expIo[2]) {mTrap, mKl10, mLoad, mLook} <= {ebusIn[22:21], ebusIn[19:18]};
      if (diagCtlStrobe && diagDs == dsSetRun) mRunState <= 1'b1;
      else if (diagCtlStrobe && diagDs == dsClearRun) mRunState <= 1'b0;
      runPipe <= {runPipe[1:0], mRunState};
      contPipe <= {contPipe[2:0], diagCtlStrobe && diagDs == dsContinue};
      // Rows freeze on the capture edge, ack follows on the same edge
      mCap <= diagReq && !mAck && !mCap;
      if (mCap) {mAck, mRows} <= {1'b1, expRows(diagSel)};
      else if (!diagReq) mAck <= 1'b0;
    end
  end

  task automatic reportValue(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    errorCount++;
    $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
  endtask

  task automatic reportFailure(input string what);
    errorCount++;
    $display("Error at %0t: %s", $time, what);
  endtask

  groupEnCheck: assert property (@(posedge conCLK) disable iff (CLK)
    condGroupEn == 8'b1 << cond[5:3])
    else reportValue("condGroupEn", $sampled(8'b1 << cond[5:3]), $sampled(condGroupEn));
  condOutCheck: assert property (@(posedge conCLK) disable iff (CLK) gotCondOut == expCondOut)
    else reportValue("named conditions/vmaSel/loadIr", $sampled(expCondOut), $sampled(gotCondOut));
  ioCheck: assert property (@(posedge conCLK) disable iff (CLK) gotIo == expIo)
    else reportValue("I/O strobes/ebusRel", $sampled(expIo), $sampled(gotIo));
  regsCheck: assert property (@(posedge conCLK) disable iff (CLK) gotRegs == expRegs)
    else reportValue("loaded enables", $sampled(expRegs), $sampled(gotRegs));
  runCheck: assert property (@(posedge conCLK) disable iff (CLK)
    {run, start} == {runPipe[2], contPipe[3]})
    else reportValue("run/start", $sampled({runPipe[2], contPipe[3]}), $sampled({run, start}));
  ackCheck: assert property (@(posedge conCLK) disable iff (CLK) diagAck == mAck)
    else reportValue("diagAck", $sampled(mAck), $sampled(diagAck));
  ebusCheck: assert property (@(posedge conCLK) disable iff (CLK)
    ebusDiag == (mAck ? mRows : '0))
    else reportValue("ebusDiag", $sampled(mAck ? mRows : '0), $sampled(ebusDiag));
  resetStrobeCheck: assert property (@(posedge conCLK) CLK |-> gotIo[4:1] == 0 && condGroupEn == 0)
    else reportFailure("an I/O strobe or condition group was active during reset");
  resetStateCheck: assert property (@(posedge conCLK) $fell(CLK) |->
    gotRegs == 7'b0000010 && !run && !start && !diagAck && ebusDiag == 0)
    else reportFailure("registers were not clear after reset");

  task automatic finishTest(input string name);
    @(negedge conCLK);
    testCount++;
    $display("Test %0d %s done, %0d errors", testCount, name, errorCount - errorsAtStart);
    errorsAtStart = errorCount;
  endtask

  task automatic loadCycle(input logic [magicWidth-1:0] func);
    @(negedge conCLK);
    {cond, magic, consoleControl, ebusSync} = {conFieldPkg::condDiagFunc, func, 2'b01};
    ebusIn = {4'($random(seed)), $random(seed)};
    repeat (3) begin
      @(negedge conCLK);
      cond = '0;
      ebusIn = {4'($random(seed)), $random(seed)};
    end
  endtask

  task automatic runFunction(input logic [dsWidth-1:0] ds);
    @(negedge conCLK);
    {diagCtlStrobe, diagDs} = {1'b1, ds};
    @(negedge conCLK);
    diagCtlStrobe = 1'b0;
  endtask

  task automatic waitAck(input logic level, input int limit);
    int n;
    n = 0;
    while (diagAck !== level && n < limit) begin
      @(negedge conCLK);
      n++;
    end
    if (diagAck !== level) reportFailure($sformatf("diagAck stuck, never went to %0b", level));
  endtask

  task automatic readBack(input logic [diagSelWidth-1:0] sel);
    @(negedge conCLK);
    cond = 6'($random(seed));
    {diagSel, diagReq} = {sel, 1'b1};
    waitAck(1'b1, 8);
    // Slow requester, select moves while still held
    @(negedge conCLK);
    diagSel = sel + 3'd1;
    repeat (2) @(negedge conCLK);
    diagReq = 1'b0;
    waitAck(1'b0, 8);
  endtask

  initial begin
    logic [31:0] r;
    seed = 32'h9acd9317;
    {errorCount, testCount, errorsAtStart} = '0;
    {cond, magic, ebusIn, diagDs, diagSel} = '0;
    {mclLoadVma, consoleControl, ebusSync, diagCtlStrobe, diagReq} = '0;
    // Every I/O function decodable while reset holds the strobes low
    cond = conFieldPkg::condDiagFunc;
    ebusSync = 1'b1;
    for (int k = 0; k < 4; k++) begin
      magic = {funcTopDigit, funcMidDigit, funcConoApr + k[2:0]};
      @(negedge conCLK);
    end
    {cond, magic, ebusSync} = '0;
    wait (CLK === 1'b0);
    for (int i = 0; i < 64; i++) begin
      @(negedge conCLK);
      {cond, diagDs} = {i[condWidth-1:0], dsIrStrobe};
      mclLoadVma = 1'($random(seed));
      diagCtlStrobe = 1'($random(seed));
    end
    finishTest("condition decode");
    diagCtlStrobe = 1'b0;
    repeat (ioCount) begin
      @(negedge conCLK);
      r = $random(seed);
      cond = r[12] ? conFieldPkg::condDiagFunc : (r[13] ? conFieldPkg::condEbusCtl : r[19:14]);
      magic = {r[0] ? 3'o0 : r[5:3], r[1] ? 3'o1 : r[8:6], r[11:9]};
      {consoleControl, ebusSync} = {r[20] & r[21], r[22]};
      ebusIn = {4'($random(seed)), $random(seed)};
    end
    finishTest("I/O function decode");
    repeat (3) begin
      loadCycle(9'o015);
      loadCycle(9'o016);
    end
    finishTest("register loading");
    {cond, magic} = '0;
    runFunction(dsSetRun);
    repeat (5) @(negedge conCLK);
    runFunction(dsClearRun);
    repeat (5) @(negedge conCLK);
    runFunction(dsContinue);
    repeat (6) @(negedge conCLK);
    finishTest("run and start");
    runFunction(dsSetRun);
    repeat (4) @(negedge conCLK);
    for (int s = 0; s < 4; s++) readBack(s[diagSelWidth-1:0]);
    finishTest("readback handshake");
    $display("Tests run %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Timeout, tests did not finish within %0d ns", watchdogNs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== conCore.f ====
design/conFieldPkg.sv
design/conDiagPkg.sv
design/condDecode.sv
design/ioFunctionDecode.sv
design/runControl.sv
design/diagStatusGather.sv
design/diagRowMux.sv
design/diagReadPort.sv
design/conCore.sv
tests/conClockGen.sv
tests/conCoreTb.sv

// ==== Bender.yml ====
package:
  name: con_core

sources:
  - design/conFieldPkg.sv
  - design/conDiagPkg.sv
  - design/condDecode.sv
  - design/ioFunctionDecode.sv
  - design/runControl.sv
  - design/diagStatusGather.sv
  - design/diagRowMux.sv
  - design/diagReadPort.sv
  - design/conCore.sv
  - target: test
    files:
      - tests/conClockGen.sv
      - tests/conCoreTb.sv
